//--- verilog/lsu_settings.svh
// LSU widths and encodings

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

//////////////////////////////
// data path widths
//////////////////////////////

// one hart word and the byte lanes it splits into
`define LSU_XLEN 32
`define LSU_BYTES 4

// DTIM depth in words, 1 KiB in total
`define LSU_DTIM_WORDS 256
// byte address bits that the DTIM decodes
`define LSU_ADR_BITS 10

//////////////////////////////
// M-stage control encodings
//////////////////////////////

// MemRWM is {read, write}, so 00 means no access in M
`define LSU_RW_READ 2'b10
`define LSU_RW_WRITE 2'b01

// access size lives in the low two bits of Funct3
`define LSU_SIZE_B 2'b00
`define LSU_SIZE_H 2'b01
`define LSU_SIZE_W 2'b10

// funct3 bit 2 picks zero extension (lbu, lhu)
`define LSU_F3_UNSIGNED 2

// AtomicM codes, where 00 is a plain load or store
`define LSU_ATOMIC_LR 2'b01
`define LSU_ATOMIC_SC 2'b10

`endif

//--- verilog/lsuPkg.sv
// LSU shared types
`default_nettype none

`include "lsu_settings.svh"

package lsuPkg;

  //////////////////////////////
  // data word views
  //////////////////////////////

  // the same 32 bits seen as byte lanes or as halfword lanes
  // store replication, load lane select and DTIM byte writes all
  // pick lanes out of this word
  typedef union packed {
    logic [`LSU_BYTES-1:0][7:0]     bytes;
    logic [`LSU_BYTES/2-1:0][15:0]  halves;
  } dataWordT;

endpackage

`default_nettype wire

//--- verilog/lsuControl.sv
// LSU control and LR/SC reservation
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsuControl (
  input  logic                      clk,
  input  logic                      arstN,
  input  logic                      StallW,
  input  logic [1:0]                MemRWM,
  input  logic [2:0]                Funct3M,
  input  logic [1:0]                AtomicM,
  input  logic [`LSU_XLEN-1:0]      IEUAdrE,
  input  logic [`LSU_XLEN-1:0]      IEUAdrM,
  output logic [`LSU_ADR_BITS-1:2]  DtimAdr,
  output logic                      DtimWriteEn,
  output logic                      DtimReadEn,
  output logic                      LoadMisalignedFaultM,
  output logic                      StoreAmoMisalignedFaultM,
  output logic                      SquashSCW,
  output logic                      CommittedM
);

  logic                  readM;
  logic                  writeM;
  logic                  misalignedM;
  logic                  lrKeptM;
  logic                  scM;
  logic                  scFailM;
  logic                  resValid;
  logic [`LSU_XLEN-1:2]  resAdr;

  //////////////////////////////
  // access decode and faults
  //////////////////////////////

  assign readM  = (MemRWM == `LSU_RW_READ);
  assign writeM = (MemRWM == `LSU_RW_WRITE);

  // bytes can sit anywhere, halfwords need an even address and
  // words need the low two bits clear
  always_comb begin
    case (Funct3M[1:0])
      `LSU_SIZE_H: misalignedM = IEUAdrM[0];
      `LSU_SIZE_W: misalignedM = |IEUAdrM[1:0];
      default:     misalignedM = 1'b0;
    endcase
  end

  assign LoadMisalignedFaultM     = readM & misalignedM;
  assign StoreAmoMisalignedFaultM = writeM & misalignedM;

  // an access that does not fault has to finish before an interrupt
  assign CommittedM = (readM | writeM) & ~misalignedM;

  //////////////////////////////
  // DTIM request
  //////////////////////////////

  // loads read ahead with the E address, stores write with the M address
  assign DtimAdr = writeM ? IEUAdrM[`LSU_ADR_BITS-1:2] : IEUAdrE[`LSU_ADR_BITS-1:2];

  // the read port is busy with the store address while a store is in M,
  // so the read data register keeps the last load word
  assign DtimReadEn = ~StallW & ~writeM;

  // faulting stores and failed SCs never reach memory
  assign DtimWriteEn = writeM & ~misalignedM & ~scFailM & ~StallW;

  //////////////////////////////
  // LR/SC reservation
  //////////////////////////////

  // a misaligned LR traps and leaves no reservation behind
  assign lrKeptM = readM & (AtomicM == `LSU_ATOMIC_LR) & ~misalignedM;
  assign scM     = writeM & (AtomicM == `LSU_ATOMIC_SC);

  // SC succeeds only on a live reservation for the same word
  assign scFailM = scM & ~(resValid & (resAdr == IEUAdrM[`LSU_XLEN-1:2]));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resValid  <= 1'b0;
      SquashSCW <= 1'b0;
    end else if (!StallW) begin
      // any SC consumes the reservation, pass or fail
      if (scM) begin
        resValid <= 1'b0;
      end else if (lrKeptM) begin
        resValid <= 1'b1;
      end
      // the W stage squashes the SC result write for one cycle
      SquashSCW <= scFailM;
    end
  end

  // reserved word address, only meaningful while resValid is set
  always_ff @(posedge clk) begin
    if (!StallW && lrKeptM) begin
      resAdr <= IEUAdrM[`LSU_XLEN-1:2];
    end
  end

endmodule

`default_nettype wire

//--- verilog/storeAlign.sv
// store data alignment
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module storeAlign (
  input  logic [1:0]             Funct3M,
  input  logic [1:0]             IEUAdrM,
  input  logic                   BigEndianM,
  input  logic [`LSU_XLEN-1:0]   WriteDataM,
  output logic [`LSU_XLEN-1:0]   StoreDataM,
  output logic [`LSU_BYTES-1:0]  ByteMaskM
);

  lsuPkg::dataWordT          wrWord;
  lsuPkg::dataWordT          leData;
  logic [`LSU_BYTES-1:0]     leMask;

  assign wrWord = WriteDataM;

  //////////////////////////////
  // lane replication
  //////////////////////////////

  // the low byte or halfword is copied into every lane, so whichever
  // lane the mask opens already holds the right value
  always_comb begin
    case (Funct3M)
      `LSU_SIZE_B: leData.bytes  = {`LSU_BYTES{wrWord.bytes[0]}};
      `LSU_SIZE_H: leData.halves = {(`LSU_BYTES/2){wrWord.halves[0]}};
      default:     leData        = wrWord;
    endcase
  end

  //////////////////////////////
  // byte mask
  //////////////////////////////

  // one bit per lane, shifted up by the offset inside the word
  always_comb begin
    case (Funct3M)
      `LSU_SIZE_B: leMask = `LSU_BYTES'(1) << IEUAdrM;
      `LSU_SIZE_H: leMask = `LSU_BYTES'(3) << {IEUAdrM[1], 1'b0};
      default:     leMask = '1;
    endcase
  end

  //////////////////////////////
  // big-endian swap
  //////////////////////////////

  // memory is addressed big-endian, so byte 0 of the hart view lands in
  // lane 3 and the mask flips with the data
  always_comb begin
    if (BigEndianM) begin
      StoreDataM = {<<8{leData}};
      ByteMaskM  = {<<{leMask}};
    end else begin
      StoreDataM = leData;
      ByteMaskM  = leMask;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dtimRam.sv
// DTIM data memory
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module dtimRam (
  input  logic                      clk,
  input  logic [`LSU_ADR_BITS-1:2]  DtimAdr,
  input  logic                      DtimReadEn,
  input  logic                      DtimWriteEn,
  input  logic [`LSU_BYTES-1:0]     ByteMaskM,
  input  logic [`LSU_XLEN-1:0]      StoreDataM,
  output logic [`LSU_XLEN-1:0]      DtimReadData
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // one entry per word, byte lanes written one at a time
  lsuPkg::dataWordT  mem [0:`LSU_DTIM_WORDS-1];
  lsuPkg::dataWordT  wrWord;

  assign wrWord = StoreDataM;

  //////////////////////////////
  // write port
  //////////////////////////////

  // only the lanes opened by the mask change
  always_ff @(posedge clk) begin
    if (DtimWriteEn) begin
      for (int i = 0; i < `LSU_BYTES; i++) begin
        if (ByteMaskM[i]) begin
          mem[DtimAdr].bytes[i] <= wrWord.bytes[i];
        end
      end
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // registered read, one cycle after the E address is presented
  // the output keeps its value whenever the read is not enabled,
  // which holds the load word through a stall
  always_ff @(posedge clk) begin
    if (DtimReadEn) begin
      DtimReadData <= mem[DtimAdr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/loadAlign.sv
// load data alignment and M-to-W register
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module loadAlign (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  StallW,
  input  logic [2:0]            Funct3M,
  input  logic [1:0]            IEUAdrM,
  input  logic                  BigEndianM,
  input  logic [`LSU_XLEN-1:0]  DtimReadData,
  output logic [`LSU_XLEN-1:0]  ReadDataW
);

  lsuPkg::dataWordT        rdWord;
  logic [7:0]              byteSel;
  logic [15:0]             halfSel;
  logic                    zeroExt;
  logic [`LSU_XLEN-1:0]    readDataM;

  //////////////////////////////
  // big-endian swap
  //////////////////////////////

  // the hart works little-endian inside, so a big-endian word is turned
  // around before any lane is picked
  always_comb begin
    if (BigEndianM) begin
      rdWord = {<<8{DtimReadData}};
    end else begin
      rdWord = DtimReadData;
    end
  end

  //////////////////////////////
  // lane select
  //////////////////////////////

  // byte lane from both offset bits, halfword lane from bit 1 only
  assign byteSel = rdWord.bytes[IEUAdrM];
  assign halfSel = rdWord.halves[IEUAdrM[1]];

  //////////////////////////////
  // extension
  //////////////////////////////

  // lbu and lhu fill with zeros, lb and lh copy the sign bit up
  assign zeroExt = Funct3M[`LSU_F3_UNSIGNED];

  always_comb begin
    case (Funct3M[1:0])
      `LSU_SIZE_B: begin
        readDataM = {{(`LSU_XLEN-8){~zeroExt & byteSel[7]}}, byteSel};
      end
      `LSU_SIZE_H: begin
        readDataM = {{(`LSU_XLEN-16){~zeroExt & halfSel[15]}}, halfSel};
      end
      default: begin
        readDataM = rdWord;
      end
    endcase
  end

  //////////////////////////////
  // M-to-W register
  //////////////////////////////

  // W sees the load result until the next edge that is not stalled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ReadDataW <= '0;
    end else if (!StallW) begin
      ReadDataW <= readDataM;
    end
  end

endmodule

`default_nettype wire

//--- verilog/lsu.sv
// load/store unit top
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsu (
  input  logic                  clk,
  input  logic                  arstN,
  input  logic                  StallW,
  input  logic                  FlushM,
  input  logic [`LSU_XLEN-1:0]  IEUAdrE,
  input  logic [1:0]            MemRWM,
  input  logic [2:0]            Funct3M,
  input  logic [1:0]            AtomicM,
  input  logic [`LSU_XLEN-1:0]  WriteDataM,
  input  logic                  BigEndianM,
  output logic [`LSU_XLEN-1:0]  IEUAdrM,
  output logic [`LSU_XLEN-1:0]  ReadDataW,
  output logic                  LoadMisalignedFaultM,
  output logic                  StoreAmoMisalignedFaultM,
  output logic                  SquashSCW,
  output logic                  CommittedM
);

  logic [`LSU_ADR_BITS-1:2]  DtimAdr;
  logic                      DtimWriteEn;
  logic                      DtimReadEn;
  logic [`LSU_XLEN-1:0]      StoreDataM;
  logic [`LSU_BYTES-1:0]     ByteMaskM;
  logic [`LSU_XLEN-1:0]      DtimReadData;

  //////////////////////////////
  // E-to-M address register
  //////////////////////////////

  // a flush only takes hold on an edge that is not stalled
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      IEUAdrM <= '0;
    end else if (!StallW) begin
      if (FlushM) begin
        IEUAdrM <= '0;
      end else begin
        IEUAdrM <= IEUAdrE;
      end
    end
  end

  //////////////////////////////
  // control
  //////////////////////////////

  lsuControl control (
    .clk, .arstN, .StallW, .MemRWM, .Funct3M, .AtomicM, .IEUAdrE, .IEUAdrM,
    .DtimAdr, .DtimWriteEn, .DtimReadEn, .LoadMisalignedFaultM,
    .StoreAmoMisalignedFaultM, .SquashSCW, .CommittedM
  );

  //////////////////////////////
  // data path
  //////////////////////////////

  // store side, lanes and mask built from the M address
  storeAlign storePath (
    .Funct3M(Funct3M[1:0]), .IEUAdrM(IEUAdrM[1:0]), .BigEndianM, .WriteDataM,
    .StoreDataM, .ByteMaskM
  );

  dtimRam dtim (
    .clk, .DtimAdr, .DtimReadEn, .DtimWriteEn, .ByteMaskM, .StoreDataM, .DtimReadData
  );

  // load side, the word read in E is trimmed during M
  loadAlign loadPath (
    .clk, .arstN, .StallW, .Funct3M, .IEUAdrM(IEUAdrM[1:0]), .BigEndianM,
    .DtimReadData, .ReadDataW
  );

endmodule

`default_nettype wire

//--- bench/lsu_properties.sv
// LSU control assertions
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsuProperties (
  input logic        clk,
  input logic        arstN,
  input logic        StallW,
  input logic [1:0]  MemRWM,
  input logic [1:0]  AtomicM,
  input logic        DtimWriteEn,
  input logic        LoadMisalignedFaultM,
  input logic        StoreAmoMisalignedFaultM,
  input logic        SquashSCW
);

  //////////////////////////////
  // memory safety
  //////////////////////////////

  // a faulting access must never reach the DTIM write port
  property noWriteOnFault;
    @(posedge clk) disable iff (!arstN)
      DtimWriteEn |-> !(LoadMisalignedFaultM || StoreAmoMisalignedFaultM);
  endproperty

  assert property (noWriteOnFault)
    else $error("DTIM write together with a misalignment fault");

  //////////////////////////////
  // LR/SC and read port use
  //////////////////////////////

  // the squash only ever follows an SC in M
  property squashAfterSc;
    @(posedge clk) disable iff (!arstN)
      $rose(SquashSCW) |-> $past(MemRWM == `LSU_RW_WRITE && AtomicM == `LSU_ATOMIC_SC);
  endproperty

  assert property (squashAfterSc)
    else $error("SquashSCW rose without an SC in the cycle before");

  // a store in M owns the DTIM address, so the load behind it lost its read
  property noLoadBehindStore;
    @(posedge clk) disable iff (!arstN)
      (MemRWM == `LSU_RW_WRITE) && !StallW |=> (MemRWM != `LSU_RW_READ);
  endproperty

  assert property (noLoadBehindStore)
    else $error("load entered E while a store was in M");

endmodule

bind lsuControl lsuProperties props0 (
  .clk, .arstN, .StallW, .MemRWM, .AtomicM, .DtimWriteEn,
  .LoadMisalignedFaultM, .StoreAmoMisalignedFaultM, .SquashSCW
);

`default_nettype wire

//--- bench/lsuTb.sv
// LSU trace-driven testbench
`timescale 1ns/100ps
`default_nettype none

`include "lsu_settings.svh"

module lsuTb;

  localparam int PollLimit = 40;
  localparam int LineLimit = 1000;

  logic                  clk;
  logic                  arstN;
  logic                  StallW;
  logic                  FlushM;
  logic [`LSU_XLEN-1:0]  IEUAdrE;
  logic [1:0]            MemRWM;
  logic [2:0]            Funct3M;
  logic [1:0]            AtomicM;
  logic [`LSU_XLEN-1:0]  WriteDataM;
  logic                  BigEndianM;
  logic [`LSU_XLEN-1:0]  IEUAdrM;
  logic [`LSU_XLEN-1:0]  ReadDataW;
  logic                  LoadMisalignedFaultM;
  logic                  StoreAmoMisalignedFaultM;
  logic                  SquashSCW;
  logic                  CommittedM;

  // every column of a trace line is read as hex
  logic [31:0]  tTest, tStall, tFlush, tAdr, tRw, tF3, tAt, tData, tBe;
  logic [31:0]  tExpRd, tExpLf, tExpSf, tExpSq, tMask;

  // M address and commit state that the stage rules predict
  logic [`LSU_XLEN-1:0]  expAdrM;
  logic                  expCommitted;

  int edgeCount = 0;
  int errorCount = 0;
  int testErrors = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int curTest = 0;
  int lineCount = 0;
  int fd;
  int fields;
  int got;
  string lineText;

  lsu dut0 (
    .clk, .arstN, .StallW, .FlushM, .IEUAdrE, .MemRWM, .Funct3M, .AtomicM,
    .WriteDataM, .BigEndianM, .IEUAdrM, .ReadDataW, .LoadMisalignedFaultM,
    .StoreAmoMisalignedFaultM, .SquashSCW, .CommittedM
  );

  //////////////////////////////
  // clock and edge counter
  //////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // polling runs on the half-ns grid, so it never lands on an edge
  always @(posedge clk) edgeCount++;

  task automatic waitRise;
    int target;
    int polls;
    target = edgeCount + 1;
    polls = 0;
    while (edgeCount < target && polls < PollLimit) begin
      #1;
      polls++;
    end
    if (edgeCount < target) begin
      $display("clock edge did not arrive in time");
      $display("FAIL: see errors above");
      $finish;
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    if (actVal !== expVal) begin
      $display("Error %s expected %h got %h", name, expVal, actVal);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic reportTest;
    $display("test %0d %s with %0d errors", curTest,
             (testErrors == 0) ? "ok" : "failed", testErrors);
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
    end
    testErrors = 0;
  endtask

  //////////////////////////////
  // stimulus and checks
  //////////////////////////////

  initial begin
    arstN = 1'b0;
    StallW = 1'b0;
    FlushM = 1'b0;
    IEUAdrE = '0;
    MemRWM = 2'b00;
    Funct3M = 3'd0;
    AtomicM = 2'b00;
    WriteDataM = '0;
    BigEndianM = 1'b0;
    // the address register leaves reset at zero
    expAdrM = '0;
    expCommitted = 1'b0;
    fd = $fopen("bench/lsu_trace.txt", "r");
    if (fd == 0) begin
      $display("trace file could not be opened");
      $display("FAIL: see errors above");
      $finish;
    end
    #0.5;
    for (int i = 0; i < 3; i++) begin
      waitRise();
    end
    #0.5 arstN = 1'b1;
    #0.5;
    while (!$feof(fd) && lineCount < LineLimit) begin
      got = $fgets(lineText, fd);
      fields = $sscanf(lineText, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       tTest, tStall, tFlush, tAdr, tRw, tF3, tAt, tData, tBe,
                       tExpRd, tExpLf, tExpSf, tExpSq, tMask);
      if (got > 0 && fields == 14) begin
        if (tTest != curTest) begin
          if (curTest != 0) begin
            reportTest();
          end
          curTest = tTest;
        end
        waitRise();
        // inputs change 1 ns after the edge and outputs are read before the fall
        #0.5;
        StallW = tStall[0];
        FlushM = tFlush[0];
        IEUAdrE = tAdr;
        MemRWM = tRw[1:0];
        Funct3M = tF3[2:0];
        AtomicM = tAt[1:0];
        WriteDataM = tData;
        BigEndianM = tBe[0];
        #3.5;
        if (tMask[0]) checkValue("ReadDataW", tExpRd, ReadDataW);
        if (tMask[1]) checkValue("LoadMisalignedFaultM", tExpLf, 32'(LoadMisalignedFaultM));
        if (tMask[2]) checkValue("StoreAmoMisalignedFaultM", tExpSf,
                                 32'(StoreAmoMisalignedFaultM));
        if (tMask[3]) checkValue("SquashSCW", tExpSq, 32'(SquashSCW));
        checkValue("IEUAdrM", expAdrM, IEUAdrM);
        // a read or a write in M is committed unless it raises a fault
        expCommitted = ((tRw[1:0] == `LSU_RW_READ) || (tRw[1:0] == `LSU_RW_WRITE)) &&
                       !tExpLf[0] && !tExpSf[0];
        checkValue("CommittedM", 32'(expCommitted), 32'(CommittedM));
        // the E address moves into M on an edge that is not stalled, unless flushed
        if (!tStall[0]) begin
          expAdrM = tFlush[0] ? '0 : tAdr;
        end
        lineCount++;
      end
    end
    if (curTest != 0) begin
      reportTest();
    end
    $fclose(fd);
    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsRun != 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/lsu_trace.txt
# test stall flush IEUAdrE | M: MemRW Funct3 Atomic WriteData BigEndian
# expected: ReadDataW LoadFault StoreFault SquashSCW | check mask (1 rd, 2 lf, 4 sf, 8 sq)
1 0 0 100 0 0 0 00000000 0 00000000 0 0 0 e
1 0 0 104 1 2 0 11223344 0 00000000 0 0 0 e
1 0 0 000 1 2 0 a5a55a5a 0 00000000 0 0 0 e
1 0 0 100 0 0 0 00000000 0 00000000 0 0 0 e
1 0 0 104 2 2 0 00000000 0 00000000 0 0 0 e
1 0 0 101 2 2 0 00000000 0 11223344 0 0 0 f
1 0 0 106 1 0 0 000000ee 0 a5a55a5a 0 0 0 f
2 0 0 104 1 1 0 00008001 0 00000000 0 0 0 e
2 0 0 000 1 0 0 000000ff 0 00000000 0 0 0 e
2 0 0 101 0 0 0 00000000 0 00000000 0 0 0 e
2 0 0 101 2 0 0 00000000 0 00000000 0 0 0 e
2 0 0 106 2 4 0 00000000 0 ffffffee 0 0 0 f
2 0 0 106 2 1 0 00000000 0 000000ee 0 0 0 f
2 0 0 104 2 5 0 00000000 0 ffff8001 0 0 0 f
2 0 0 101 2 2 0 00000000 0 00008001 0 0 0 f
2 0 0 102 1 1 0 0000beef 0 80015aff 0 1 0 f
3 0 0 000 1 2 0 12345678 0 00000000 0 1 0 e
3 0 0 106 0 0 0 00000000 0 00000000 0 0 0 e
3 0 0 103 2 2 0 00000000 0 00000000 1 0 0 e
3 0 0 100 2 1 0 00000000 0 00000000 1 0 0 e
3 0 0 108 2 2 0 00000000 0 00000000 0 0 0 e
3 0 0 000 1 2 0 01020304 1 1122ee44 0 0 0 f
4 0 0 108 0 0 0 00000000 0 00000000 0 0 0 e
4 0 0 108 2 2 0 00000000 0 00000000 0 0 0 e
4 0 0 109 2 4 0 00000000 1 04030201 0 0 0 f
4 0 0 10a 2 4 0 00000000 1 00000004 0 0 0 f
4 0 0 108 2 5 0 00000000 1 00000003 0 0 0 f
4 0 0 10c 2 2 0 00000000 1 00000102 0 0 0 f
4 0 0 000 1 2 0 00000000 0 01020304 0 0 0 f
5 0 0 10c 0 0 0 00000000 0 00000000 0 0 0 e
5 0 0 10c 2 2 1 00000000 0 00000000 0 0 0 e
5 0 0 10c 1 2 2 cafe0001 0 00000000 0 0 0 f
5 0 0 000 1 2 2 dead0002 0 00000000 0 0 0 e
5 0 0 100 0 0 0 00000000 0 00000000 0 0 1 e
5 0 0 10c 2 2 1 00000000 0 00000000 0 0 0 e
5 0 0 000 1 2 2 bad00003 0 1122ee44 0 0 0 f
5 0 0 10c 0 0 0 00000000 0 00000000 0 0 1 e
5 0 0 104 2 2 0 00000000 0 00000000 0 0 0 e
5 0 0 104 2 2 0 00000000 0 cafe0001 0 0 0 f
6 1 0 000 0 0 0 00000000 0 80015aff 0 0 0 f
6 1 0 000 1 2 0 00000000 0 80015aff 0 0 0 f
6 0 0 104 0 0 0 00000000 0 80015aff 0 0 0 f
6 0 0 000 2 2 0 00000000 0 00000000 0 0 0 e
6 0 0 000 0 0 0 00000000 0 80015aff 0 0 0 f

//--- lsu.f
+incdir+verilog
verilog/lsuPkg.sv
verilog/lsuControl.sv
verilog/storeAlign.sv
verilog/dtimRam.sv
verilog/loadAlign.sv
verilog/lsu.sv
bench/lsu_properties.sv
bench/lsuTb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lsuPkg.sv
      - verilog/lsuControl.sv
      - verilog/storeAlign.sv
      - verilog/dtimRam.sv
      - verilog/loadAlign.sv
      - verilog/lsu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/lsu_properties.sv
      - bench/lsuTb.sv
